//--- logic/wr_seq_pkg.sv
// write sequencer package
// sizes shared by the card write path and the data mux state encoding

package wr_seq_pkg;

    // --------------------
    // channel and field widths
    // --------------------
    localparam int n_dests       = 4;   // destination channels
    localparam int dest_bits     = 2;   // destination index
    localparam int pid_bits      = 6;   // process id
    localparam int len_bits      = 16;  // request length in bytes
    localparam int vaddr_bits    = 32;  // request address, passed through untouched
    localparam int data_bits     = 64;  // one data beat

    // 8 bytes per beat
    localparam int beat_log_bits = 3;

    // beats minus one, len_bits - beat_log_bits wide
    localparam int blen_bits     = len_bits - beat_log_bits;

    // --------------------
    // queue sizing
    // --------------------
    localparam int n_outstanding = 8;   // bursts pending per destination
    localparam int qptr_bits     = 3;   // log2 of n_outstanding

    // --------------------
    // data mux fsm
    // --------------------
    typedef enum logic {
        mux_idle,   // waiting for a queue head
        mux_burst   // moving beats of the latched burst
    } mux_state_t;

endpackage

//--- logic/dest_req_seq.sv
// destination request sequencer
// forwards each accepted request through an output register and pushes
// a burst entry (pid, beats minus one) into the addressed destination queue

module dest_req_seq import wr_seq_pkg::*; (
    input  logic                  aclk,
    input  logic                  rst_n,

    // incoming requests
    input  logic                  s_req_valid,
    output logic                  s_req_ready,
    input  logic [vaddr_bits-1:0] s_req_vaddr,
    input  logic [len_bits-1:0]   s_req_len,
    input  logic [pid_bits-1:0]   s_req_pid,
    input  logic [dest_bits-1:0]  s_req_dest,

    // forwarded requests
    output logic                  m_req_valid,
    input  logic                  m_req_ready,
    output logic [vaddr_bits-1:0] m_req_vaddr,
    output logic [len_bits-1:0]   m_req_len,
    output logic [pid_bits-1:0]   m_req_pid,
    output logic [dest_bits-1:0]  m_req_dest,

    // pushes into the per destination queues
    output logic [n_dests-1:0]    q_push_valid,
    input  logic [n_dests-1:0]    q_push_ready,   // not full
    output logic [pid_bits-1:0]   q_push_pid,
    output logic [blen_bits-1:0]  q_push_blen
);

    logic                req_reg_free;  // output stage can load this cycle
    logic                req_accept;    // handshake on s_req
    logic [len_bits-1:0] len_m1;

    // --------------------
    // acceptance
    // --------------------
    assign req_reg_free = !m_req_valid || m_req_ready;       // empty or draining
    assign s_req_ready  = q_push_ready[s_req_dest] && req_reg_free;
    assign req_accept   = s_req_valid && s_req_ready;

    // beats minus one, partial last beat rounds up
    assign len_m1      = s_req_len - 1'b1;
    assign q_push_blen = len_m1[len_bits-1:beat_log_bits];
    assign q_push_pid  = s_req_pid;

    // steer the push to the addressed queue only
    always_comb begin
        for (int i = 0; i < n_dests; i++) begin
            q_push_valid[i] = req_accept && (s_req_dest == dest_bits'(i));
        end
    end

    // --------------------
    // forwarded request register
    // --------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            m_req_valid <= 1'b0;
        end else if (req_accept) begin
            m_req_valid <= 1'b1;        // new item, may replace one leaving now
        end else if (m_req_ready) begin
            m_req_valid <= 1'b0;        // drained, nothing behind it
        end
    end

    // payload only moves on accept, so it holds under a stall
    always_ff @(posedge aclk) begin
        if (req_accept) begin
            m_req_vaddr <= s_req_vaddr;
            m_req_len   <= s_req_len;
            m_req_pid   <= s_req_pid;
            m_req_dest  <= s_req_dest;
        end
    end

endmodule

//--- logic/seq_queue.sv
// sequencer queue
// circular buffer of pending burst entries for one destination,
// head entry presented from a register

module seq_queue import wr_seq_pkg::*; (
    input  logic                 aclk,
    input  logic                 rst_n,

    input  logic                 push_valid,
    output logic                 push_ready,
    input  logic [pid_bits-1:0]  push_pid,
    input  logic [blen_bits-1:0] push_blen,

    output logic                 head_valid,
    output logic [pid_bits-1:0]  head_pid,
    output logic [blen_bits-1:0] head_blen,
    input  logic                 pop         // one pulse per finished burst
);

    logic [pid_bits-1:0]  mem_pid  [n_outstanding];
    logic [blen_bits-1:0] mem_blen [n_outstanding];

    logic [qptr_bits-1:0] wr_ptr;
    logic [qptr_bits-1:0] rd_ptr;
    logic [qptr_bits:0]   count;    // entries held, head included
    logic                 push_en;

    // full queue still takes a push when the head leaves this cycle
    assign push_ready = (count != (qptr_bits + 1)'(n_outstanding)) || pop;
    assign push_en    = push_valid && push_ready;

    // --------------------
    // storage
    // --------------------
    always_ff @(posedge aclk) begin
        if (push_en) begin
            mem_pid[wr_ptr]  <= push_pid;
            mem_blen[wr_ptr] <= push_blen;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_en) wr_ptr <= wr_ptr + 1'b1;
            if (pop)     rd_ptr <= rd_ptr + 1'b1;
            if (push_en && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // --------------------
    // head register
    // --------------------
    // a pop leaves one idle cycle so the old head is never seen twice
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            head_valid <= 1'b0;
        end else begin
            head_valid <= (count != '0) && !pop;
        end
    end

    always_ff @(posedge aclk) begin
        head_pid  <= mem_pid[rd_ptr];
        head_blen <= mem_blen[rd_ptr];
    end

endmodule

//--- logic/data_rr_mux.sv
// round robin data mux
// picks queue heads in cyclic order and moves each burst's beats from the
// chosen data input to one registered output tagged with dest, pid and last

module data_rr_mux import wr_seq_pkg::*; (
    input  logic                 aclk,
    input  logic                 rst_n,

    // queue heads, one per destination
    input  logic [n_dests-1:0]   q_head_valid,
    input  logic [pid_bits-1:0]  q_head_pid  [n_dests],
    input  logic [blen_bits-1:0] q_head_blen [n_dests],
    output logic [n_dests-1:0]   q_pop,

    // data inputs
    input  logic [n_dests-1:0]   s_data_valid,
    output logic [n_dests-1:0]   s_data_ready,
    input  logic [data_bits-1:0] s_data [n_dests],

    // merged data output
    output logic                 m_data_valid,
    input  logic                 m_data_ready,
    output logic [data_bits-1:0] m_data,
    output logic                 m_data_last,
    output logic [dest_bits-1:0] m_data_dest,
    output logic [pid_bits-1:0]  m_data_pid
);

    mux_state_t           state;
    logic [dest_bits-1:0] rr_ptr;       // first candidate next time in idle
    logic [dest_bits-1:0] sel;          // destination of the running burst
    logic [pid_bits-1:0]  sel_pid;
    logic [blen_bits-1:0] beat_cnt;     // beats left minus one

    logic                 pick_found;
    logic [dest_bits-1:0] pick_idx;
    logic                 out_free;     // output register can take a beat
    logic                 beat_xfer;
    logic                 last_xfer;

    // --------------------
    // arbitration
    // --------------------
    // first valid head at or after rr_ptr
    always_comb begin
        logic [dest_bits-1:0] idx;
        pick_found = 1'b0;
        pick_idx   = rr_ptr;
        for (int k = 0; k < n_dests; k++) begin
            idx = rr_ptr + dest_bits'(k);   // wraps, n_dests fills the index
            if (!pick_found && q_head_valid[idx]) begin
                pick_found = 1'b1;
                pick_idx   = idx;
            end
        end
    end

    // --------------------
    // beat handshake
    // --------------------
    assign out_free  = !m_data_valid || m_data_ready;
    assign beat_xfer = (state == mux_burst) && out_free && s_data_valid[sel];
    assign last_xfer = beat_xfer && (beat_cnt == '0);

    // only the selected input sees ready
    always_comb begin
        s_data_ready = '0;
        if (state == mux_burst) begin
            s_data_ready[sel] = out_free;
        end
    end

    // release the head together with the last beat
    always_comb begin
        q_pop = '0;
        if (last_xfer) begin
            q_pop[sel] = 1'b1;
        end
    end

    // --------------------
    // fsm
    // --------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state  <= mux_idle;
            rr_ptr <= '0;
        end else begin
            case (state)
                mux_idle: begin
                    if (pick_found) state <= mux_burst;
                end
                mux_burst: begin
                    if (last_xfer) begin
                        state  <= mux_idle;
                        rr_ptr <= sel + 1'b1;   // next one after the winner
                    end
                end
                default: state <= mux_idle;
            endcase
        end
    end

    // burst context, latched when leaving idle
    always_ff @(posedge aclk) begin
        if (state == mux_idle && pick_found) begin
            sel      <= pick_idx;
            sel_pid  <= q_head_pid[pick_idx];
            beat_cnt <= q_head_blen[pick_idx];
        end else if (beat_xfer) begin
            beat_cnt <= beat_cnt - 1'b1;
        end
    end

    // --------------------
    // output register
    // --------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            m_data_valid <= 1'b0;
            m_data_last  <= 1'b0;
        end else if (beat_xfer) begin
            m_data_valid <= 1'b1;
            m_data_last  <= (beat_cnt == '0);
        end else if (m_data_ready) begin
            m_data_valid <= 1'b0;       // drained with no beat behind
            m_data_last  <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (beat_xfer) begin
            m_data      <= s_data[sel];
            m_data_dest <= sel;
            m_data_pid  <= sel_pid;
        end
    end

endmodule

//--- logic/card_wr_path.sv
// card write path top
// request sequencer feeding one burst queue per destination and a
// round robin mux that merges the destination data streams

module card_wr_path import wr_seq_pkg::*; (
    input  logic                  aclk,
    input  logic                  rst_n,

    // requests in
    input  logic                  s_req_valid,
    output logic                  s_req_ready,
    input  logic [vaddr_bits-1:0] s_req_vaddr,
    input  logic [len_bits-1:0]   s_req_len,
    input  logic [pid_bits-1:0]   s_req_pid,
    input  logic [dest_bits-1:0]  s_req_dest,

    // requests out
    output logic                  m_req_valid,
    input  logic                  m_req_ready,
    output logic [vaddr_bits-1:0] m_req_vaddr,
    output logic [len_bits-1:0]   m_req_len,
    output logic [pid_bits-1:0]   m_req_pid,
    output logic [dest_bits-1:0]  m_req_dest,

    // per destination data in
    input  logic [n_dests-1:0]    s_data_valid,
    output logic [n_dests-1:0]    s_data_ready,
    input  logic [data_bits-1:0]  s_data [n_dests],

    // merged data out
    output logic                  m_data_valid,
    input  logic                  m_data_ready,
    output logic [data_bits-1:0]  m_data,
    output logic                  m_data_last,
    output logic [dest_bits-1:0]  m_data_dest,
    output logic [pid_bits-1:0]   m_data_pid
);

    // sequencer to queues
    logic [n_dests-1:0]   q_push_valid;
    logic [n_dests-1:0]   q_push_ready;
    logic [pid_bits-1:0]  q_push_pid;     // shared, valid bit steers
    logic [blen_bits-1:0] q_push_blen;

    // queues to mux
    logic [n_dests-1:0]   q_head_valid;
    logic [pid_bits-1:0]  q_head_pid  [n_dests];
    logic [blen_bits-1:0] q_head_blen [n_dests];
    logic [n_dests-1:0]   q_pop;

    // --------------------
    // request side
    // --------------------
    dest_req_seq u_seq (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .s_req_valid  (s_req_valid),
        .s_req_ready  (s_req_ready),
        .s_req_vaddr  (s_req_vaddr),
        .s_req_len    (s_req_len),
        .s_req_pid    (s_req_pid),
        .s_req_dest   (s_req_dest),
        .m_req_valid  (m_req_valid),
        .m_req_ready  (m_req_ready),
        .m_req_vaddr  (m_req_vaddr),
        .m_req_len    (m_req_len),
        .m_req_pid    (m_req_pid),
        .m_req_dest   (m_req_dest),
        .q_push_valid (q_push_valid),
        .q_push_ready (q_push_ready),
        .q_push_pid   (q_push_pid),
        .q_push_blen  (q_push_blen)
    );

    // one burst queue per destination, index gives the dest
    for (genvar i = 0; i < n_dests; i++) begin : g_queue
        seq_queue u_queue (
            .aclk       (aclk),
            .rst_n      (rst_n),
            .push_valid (q_push_valid[i]),
            .push_ready (q_push_ready[i]),
            .push_pid   (q_push_pid),
            .push_blen  (q_push_blen),
            .head_valid (q_head_valid[i]),
            .head_pid   (q_head_pid[i]),
            .head_blen  (q_head_blen[i]),
            .pop        (q_pop[i])
        );
    end

    // --------------------
    // data side
    // --------------------
    data_rr_mux u_mux (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .q_head_valid (q_head_valid),
        .q_head_pid   (q_head_pid),
        .q_head_blen  (q_head_blen),
        .q_pop        (q_pop),
        .s_data_valid (s_data_valid),
        .s_data_ready (s_data_ready),
        .s_data       (s_data),
        .m_data_valid (m_data_valid),
        .m_data_ready (m_data_ready),
        .m_data       (m_data),
        .m_data_last  (m_data_last),
        .m_data_dest  (m_data_dest),
        .m_data_pid   (m_data_pid)
    );

endmodule

//--- dv/card_wr_path_properties.sv
// card write path properties
// request length, stall stability, pop and last beat rules on the top level

module card_wr_path_properties import wr_seq_pkg::*; (
    input logic                aclk,
    input logic                rst_n,
    input logic                s_req_valid,
    input logic [len_bits-1:0] s_req_len,
    input logic                m_req_valid,
    input logic                m_req_ready,
    input logic                m_data_valid,
    input logic                m_data_ready,
    input logic                m_data_last,
    input logic [n_dests-1:0]  q_pop,
    input mux_state_t          mux_state      // data mux fsm
);
    timeunit 1ns;
    timeprecision 1ps;

    // zero length requests are illegal
    a_len_nonzero: assert property (@(posedge aclk) disable iff (!rst_n)
        s_req_valid |-> (s_req_len != '0))
        else $error("request presented with zero length");

    // --------------------
    // stall stability
    // --------------------
    a_m_req_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        (m_req_valid && !m_req_ready) |=> m_req_valid)
        else $error("m_req_valid dropped under a stall");

    a_m_data_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        (m_data_valid && !m_data_ready) |=> m_data_valid)
        else $error("m_data_valid dropped under a stall");

    // one burst ends per cycle at most
    a_pop_onehot: assert property (@(posedge aclk) disable iff (!rst_n)
        $onehot0(q_pop))
        else $error("more than one queue popped in a cycle");

    // a fresh last beat is loaded only from a running burst
    a_last_in_burst: assert property (@(posedge aclk) disable iff (!rst_n)
        $rose(m_data_last) |-> $past(mux_state == mux_burst))
        else $error("m_data_last raised outside a burst");

endmodule

//--- dv/card_wr_path_tb.sv
// card write path testbench
// random and directed requests, scoreboards for forwarded requests,
// burst framing per destination and data order

module card_wr_path_tb import wr_seq_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_rand_reqs  = 60;
    localparam int n_reqs_total = n_rand_reqs + n_outstanding + 1 + (n_dests - 1) + 2 * n_dests;
    localparam int cycle_limit  = 64 * n_reqs_total + 2000;

    typedef struct packed {
        logic [vaddr_bits-1:0] vaddr;
        logic [len_bits-1:0]   len;
        logic [pid_bits-1:0]   pid;
        logic [dest_bits-1:0]  dest;
    } req_t;

    logic aclk = 1'b0;
    logic rst_n;
    logic s_req_valid, s_req_ready, m_req_valid, m_req_ready;
    logic [vaddr_bits-1:0] s_req_vaddr, m_req_vaddr;
    logic [len_bits-1:0]   s_req_len, m_req_len;
    logic [pid_bits-1:0]   s_req_pid, m_req_pid, m_data_pid;
    logic [dest_bits-1:0]  s_req_dest, m_req_dest, m_data_dest;
    logic [n_dests-1:0]    s_data_valid, s_data_ready;
    logic [data_bits-1:0]  s_data [n_dests];
    logic [data_bits-1:0]  m_data;
    logic m_data_valid, m_data_ready, m_data_last;

    // stimulus modes, changed between test phases
    logic               ready_rand, data_gaps, rr_check;
    logic [n_dests-1:0] data_hold;              // no new data valid on these

    // scoreboards
    req_t                 req_exp     [$];       // acceptance order
    logic [pid_bits-1:0]  burst_pid   [n_dests][$];
    int                   burst_beats [n_dests][$];
    logic [data_bits-1:0] words       [n_dests][$];
    int                   beat_idx    [n_dests];
    logic [dest_bits-1:0] last_dest;            // dest of the latest burst start

    logic [31:0] lcg_state = 32'd20826;
    int          n_mismatch = 0;
    int          n_other = 0;
    int          cycle_cnt = 0;

    card_wr_path dut0 (.*);

    bind card_wr_path card_wr_path_properties props0 (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .s_req_valid  (s_req_valid),
        .s_req_len    (s_req_len),
        .m_req_valid  (m_req_valid),
        .m_req_ready  (m_req_ready),
        .m_data_valid (m_data_valid),
        .m_data_ready (m_data_ready),
        .m_data_last  (m_data_last),
        .q_pop        (q_pop),
        .mux_state    (u_mux.state)
    );

    always #2 aclk = ~aclk;     // 4 ns period

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);   // fold high bits down
    endfunction

    // beats per burst, partial last beat counts
    function automatic int beats_of(input logic [len_bits-1:0] len);
        return (int'(len) + 7) / 8;
    endfunction

    function automatic int pending_bursts();
        int n;
        n = 0;
        for (int d = 0; d < n_dests; d++) n += burst_beats[d].size();
        return n;
    endfunction

    task automatic compare_val(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            n_mismatch++;
        end
    endtask

    task automatic report_other(input string msg);
        $display("ERROR %s", msg);
        n_other++;
    endtask

    task automatic finish_run();
        $display("error count: %0d value mismatches, %0d other failures", n_mismatch, n_other);
        if (n_mismatch + n_other == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic check_reset_outputs();
        compare_val("m_req_valid", 64'(0), 64'(m_req_valid));
        compare_val("m_data_valid", 64'(0), 64'(m_data_valid));
        compare_val("m_data_last", 64'(0), 64'(m_data_last));
        compare_val("s_data_ready", 64'(0), 64'(s_data_ready));
    endtask

    // present one request, withdraw it after acceptance or wait_max edges
    task automatic try_req(input logic [dest_bits-1:0] dest, input logic [len_bits-1:0] len,
                           input int wait_max, output bit ok);
        int n;
        n = 0;
        ok = 1'b0;
        s_req_valid = 1'b1;
        s_req_vaddr = next_rand();
        s_req_len   = len;
        s_req_pid   = pid_bits'(next_rand());
        s_req_dest  = dest;
        while (!ok && n < wait_max) begin
            @(posedge aclk);
            ok = s_req_ready;                   // valid is high, so ready means taken
            n++;
        end
        #1;
        s_req_valid = 1'b0;
    endtask

    task automatic send_req(input logic [dest_bits-1:0] dest, input logic [len_bits-1:0] len);
        bit ok;
        try_req(dest, len, 1000, ok);
        if (!ok) report_other($sformatf("request to dest %0d never accepted", dest));
    endtask

    // queues empty and output register drained
    task automatic wait_drained();
        @(negedge aclk);
        while (req_exp.size() != 0 || pending_bursts() != 0 || m_data_valid) begin
            @(negedge aclk);
        end
        @(posedge aclk);
        #1;
    endtask

    // --------------------
    // stream drivers, 1 ns after the edge
    // --------------------
    always @(posedge aclk) begin
        logic [n_dests-1:0] took;
        took = s_data_valid & s_data_ready;
        #1;
        m_req_ready  = ready_rand ? (next_rand() % 4 != 0) : 1'b1;
        m_data_ready = ready_rand ? (next_rand() % 3 != 0) : 1'b1;
        for (int d = 0; d < n_dests; d++) begin
            if (!s_data_valid[d] || took[d]) begin      // valid holds until taken
                s_data_valid[d] = !data_hold[d] && (!data_gaps || next_rand() % 3 != 0);
                s_data[d]       = {next_rand(), next_rand()};
            end
        end
    end

    // --------------------
    // scoreboard and compare
    // --------------------
    always @(posedge aclk) begin
        req_t r;
        int   d;
        bit   last_exp;
        if (rst_n) begin
            if (s_req_valid && s_req_ready) begin
                req_exp.push_back({s_req_vaddr, s_req_len, s_req_pid, s_req_dest});
                burst_pid[s_req_dest].push_back(s_req_pid);
                burst_beats[s_req_dest].push_back(beats_of(s_req_len));
            end
            if ((s_data_ready & (s_data_ready - 1'b1)) != '0) begin
                report_other("s_data_ready high on more than one destination");
            end
            for (int k = 0; k < n_dests; k++) begin
                if (s_data_valid[k] && s_data_ready[k]) words[k].push_back(s_data[k]);
            end
            if (m_req_valid && m_req_ready) begin
                if (req_exp.size() == 0) begin
                    report_other("request forwarded that was never accepted");
                end else begin
                    r = req_exp.pop_front();
                    compare_val("m_req_vaddr", 64'(r.vaddr), 64'(m_req_vaddr));
                    compare_val("m_req_len", 64'(r.len), 64'(m_req_len));
                    compare_val("m_req_pid", 64'(r.pid), 64'(m_req_pid));
                    compare_val("m_req_dest", 64'(r.dest), 64'(m_req_dest));
                end
            end
            if (m_data_valid && m_data_ready) begin
                d = int'(m_data_dest);
                if (burst_beats[d].size() == 0 || words[d].size() == 0) begin
                    report_other($sformatf("data beat for dest %0d with no burst or word", d));
                end else begin
                    last_exp = (beat_idx[d] == burst_beats[d][0] - 1);
                    compare_val("m_data", words[d].pop_front(), m_data);
                    compare_val("m_data_pid", 64'(burst_pid[d][0]), 64'(m_data_pid));
                    compare_val("m_data_last", 64'(last_exp), 64'(m_data_last));
                    if (beat_idx[d] == 0) begin         // burst start
                        if (rr_check) begin
                            compare_val("m_data_dest", 64'(dest_bits'(last_dest + 1'b1)),
                                        64'(m_data_dest));
                        end
                        last_dest = m_data_dest;
                    end
                    if (last_exp) begin
                        void'(burst_pid[d].pop_front());
                        void'(burst_beats[d].pop_front());
                        beat_idx[d] = 0;
                    end else begin
                        beat_idx[d]++;
                    end
                end
            end
        end
    end

    // run limit
    always @(posedge aclk) begin
        cycle_cnt++;
        if (cycle_cnt == cycle_limit) begin
            $display("timeout, the run did not end within %0d cycles", cycle_limit);
            n_other++;
            finish_run();
        end
    end

    // --------------------
    // test sequence
    // --------------------
    initial begin
        logic [dest_bits-1:0] held;
        logic [dest_bits-1:0] first;
        int                   n_ok;
        bit                   ok;
        rst_n        = 1'b0;
        s_req_valid  = 1'b0;
        s_req_vaddr  = '0;
        s_req_len    = len_bits'(1);
        s_req_pid    = '0;
        s_req_dest   = '0;
        m_req_ready  = 1'b0;
        m_data_ready = 1'b0;
        s_data_valid = '0;
        for (int d = 0; d < n_dests; d++) begin
            s_data[d]   = '0;
            beat_idx[d] = 0;
        end
        ready_rand = 1'b0;
        data_gaps  = 1'b0;
        rr_check   = 1'b0;
        data_hold  = '0;
        last_dest  = '0;

        // reset, outputs low from the second edge on
        for (int i = 0; i < 10; i++) begin
            @(posedge aclk);
            if (i > 0) check_reset_outputs();
        end
        #1 rst_n = 1'b1;
        @(posedge aclk);
        check_reset_outputs();
        #1;

        // random traffic with stalls and data gaps
        ready_rand = 1'b1;
        data_gaps  = 1'b1;
        for (int i = 0; i < n_rand_reqs; i++) begin
            send_req(dest_bits'(next_rand() % n_dests), len_bits'(1 + next_rand() % 64));
        end
        wait_drained();

        // one destination without data fills its queue
        ready_rand = 1'b0;
        data_gaps  = 1'b0;
        held       = dest_bits'(next_rand() % n_dests);
        data_hold[held] = 1'b1;
        n_ok = 0;
        for (int i = 0; i <= n_outstanding; i++) begin
            try_req(held, len_bits'(9 + next_rand() % 56), 20, ok);   // two beats or more
            if (ok) n_ok++;
        end
        compare_val("accepted for held dest", 64'(n_outstanding), 64'(n_ok));
        for (int k = 1; k < n_dests; k++) begin
            send_req(dest_bits'(held + k), len_bits'(1 + next_rand() % 64));
        end
        data_hold[held] = 1'b0;
        wait_drained();

        // every dest queued, bursts must rotate from the pointer
        rr_check = 1'b1;
        first    = dest_bits'(last_dest + 1'b1);
        for (int i = 0; i < 2 * n_dests; i++) begin
            send_req(dest_bits'(first + i), len_bits'(1 + next_rand() % 64));
        end
        wait_drained();
        rr_check = 1'b0;

        for (int d = 0; d < n_dests; d++) begin
            if (words[d].size() != 0) report_other($sformatf("dest %0d data left over", d));
        end
        finish_run();
    end

endmodule

//--- verilog.f
logic/wr_seq_pkg.sv
logic/dest_req_seq.sv
logic/seq_queue.sv
logic/data_rr_mux.sv
logic/card_wr_path.sv
dv/card_wr_path_properties.sv
dv/card_wr_path_tb.sv

//--- Makefile
# Verilator build and run of the card write path testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= card_wr_path_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, pass only if the log holds the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
